//--- exe.f
+incdir+.
exePkg.sv
idExeReg.sv
exeAlu.sv
mulDivUnit.sv
exeStage.sv
exeMemReg.sv
exeTop.sv
exe_checker.sv
tb_exeTop.sv

//--- Makefile
TOP := tb_exeTop

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f exe.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f exe.f --top-module $(TOP) -o simv
	./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- exe_stim.txt
# kind(0 alu,1 muldiv,2 aborted div) chain busA busB imm pc rs rt rd aluOp srcB shamt dstSel
# readSel branch regWr, then expected: memResult memDst memRegWr memOverflow exeFlushId
0 0 00000005 00000007 00000000 00000100 01 02 03 01 0 0 0 0 0 1 0000000c 03 1 0 0
0 0 0000000a 00000000 00000003 00000104 05 04 00 03 1 0 1 0 0 1 00000007 04 1 0 0
0 0 f0f0ff00 0ff0f0f0 00000000 00000108 06 07 08 04 0 0 0 0 0 1 00f0f000 08 1 0 0
0 0 f0f0ff00 0ff0f0f0 00000000 0000010c 06 07 0a 06 0 0 0 0 0 1 ff000ff0 0a 1 0 0
0 0 f0f0ff00 0ff0f0f0 00000000 00000110 06 07 0b 07 0 0 0 0 0 1 000f000f 0b 1 0 0
0 0 ffffffff 00000001 00000000 00000114 06 07 0c 08 0 0 0 0 0 1 00000001 0c 1 0 0
0 0 ffffffff 00000001 00000000 00000118 06 07 0d 09 0 0 0 0 0 1 00000000 0d 1 0 0
0 0 00000000 00000003 00000100 0000011c 00 07 0e 0a 0 1 0 0 0 1 00000030 0e 1 0 0
0 0 00000008 80000000 00000000 00000120 06 07 0f 0b 0 0 0 0 0 1 00800000 0f 1 0 0
0 0 00000000 80000000 00000100 00000124 00 07 10 0c 0 1 0 0 0 1 f8000000 10 1 0 0
0 0 00000000 00000000 00001234 00000128 00 11 00 0d 1 0 1 0 0 1 12340000 11 1 0 0
0 0 7fffffff 00000001 00000000 0000012c 06 07 12 00 0 0 0 0 0 1 80000000 12 0 1 0
0 0 7fffffff 00000001 00000000 00000130 06 07 13 01 0 0 0 0 0 1 80000000 13 1 0 0
0 0 80000000 00000001 00000000 00000134 06 07 14 02 0 0 0 0 0 1 7fffffff 14 0 1 0
0 0 00000010 00000020 00000000 00000138 06 07 15 01 0 0 0 0 0 1 00000030 15 1 0 0
0 1 00000000 00000001 00000000 0000013c 15 16 17 01 0 0 0 0 0 1 00000031 17 1 0 0
0 0 00000100 00000000 00000000 00000140 06 07 00 01 0 0 0 0 0 1 00000100 00 1 0 0
0 1 00000000 00000002 00000000 00000144 00 18 19 01 0 0 0 0 0 1 00000002 19 1 0 0
0 1 00000005 00000000 00000000 00000148 1a 19 1b 03 0 0 0 0 0 1 00000003 1b 1 0 0
0 0 00000005 00000005 00000010 00000200 1c 1d 00 01 0 0 0 0 1 0 00000000 00 0 0 1
0 0 00000005 00000005 00000010 00000204 1c 1d 00 01 0 0 0 0 2 0 00000000 00 0 0 0
0 0 00000000 00000000 fffffffc 00000300 1c 1d 00 01 0 0 0 0 3 0 00000000 00 0 0 1
0 0 00000000 00000000 fffffffc 00000304 1c 1d 00 01 0 0 0 0 4 0 00000000 00 0 0 0
0 0 80000000 00000000 fffffffc 00000308 1c 1d 00 01 0 0 0 0 4 0 00000000 00 0 0 1
0 0 00000000 00000000 00000008 00000400 1c 1d 00 01 0 0 2 0 5 1 00000408 1f 1 0 1
0 0 00000003 00000004 00000000 00000500 06 07 1e 01 0 0 0 0 0 1 00000007 1e 1 0 0
0 1 00000000 00000007 00000000 00000504 1e 01 00 01 0 0 0 0 1 0 00000000 00 0 0 1
1 0 fffffffd 00000007 00000000 00000600 02 03 00 0e 0 0 0 0 0 0 00000000 00 0 0 0
0 0 00000000 00000000 00000000 00000604 00 00 04 01 0 0 0 1 0 1 ffffffff 04 1 0 0
0 0 00000000 00000000 00000000 00000608 00 00 05 01 0 0 0 2 0 1 ffffffeb 05 1 0 0
1 0 ffffffff 00000002 00000000 0000060c 02 03 00 0f 0 0 0 0 0 0 00000000 00 0 0 0
0 0 00000000 00000000 00000000 00000610 00 00 06 01 0 0 0 1 0 1 00000001 06 1 0 0
0 0 00000000 00000000 00000000 00000614 00 00 07 01 0 0 0 2 0 1 fffffffe 07 1 0 0
1 0 fffffff9 00000002 00000000 00000618 02 03 00 10 0 0 0 0 0 0 00000000 00 0 0 0
0 0 00000000 00000000 00000000 0000061c 00 00 08 01 0 0 0 1 0 1 ffffffff 08 1 0 0
0 0 00000000 00000000 00000000 00000620 00 00 09 01 0 0 0 2 0 1 fffffffd 09 1 0 0
1 0 00001234 00000000 00000000 00000624 02 03 00 11 0 0 0 0 0 0 00000000 00 0 0 0
0 0 00000000 00000000 00000000 00000628 00 00 0a 01 0 0 0 1 0 1 00001234 0a 1 0 0
0 0 00000000 00000000 00000000 0000062c 00 00 0b 01 0 0 0 2 0 1 ffffffff 0b 1 0 0
0 0 cafe0000 00000000 00000000 00000630 00 00 00 12 0 0 0 0 0 0 00000000 00 0 0 0
0 0 00000000 00000000 00000000 00000634 00 00 0c 01 0 0 0 1 0 1 cafe0000 0c 1 0 0
2 0 00000063 00000005 00000000 00000638 00 00 00 10 0 0 0 0 0 0 00000000 00 0 0 0
0 0 00000000 00000000 00000000 0000063c 00 00 0d 01 0 0 0 1 0 1 cafe0000 0d 1 0 0
0 0 00000000 00000000 00000000 00000640 00 00 0e 01 0 0 0 2 0 1 ffffffff 0e 1 0 0

//--- tb_exeTop.sv
`timescale 1ns/1ps
`include "exe_macros.svh"

module tb_exeTop;
    import exePkg::*;

    localparam int NumCols    = 21;
    localparam int MaxItems   = 128;
    localparam int StallLimit = `EXE_MD_CYCLES + 8;
    localparam int DrainLimit = 20;

    logic    clk = 1'b0;
    logic    rstN;
    logic    exeWr;
    logic    exeFlush;
    wordT    idBusA;
    wordT    idBusB;
    wordT    idImm;
    wordT    idPc;
    regIdxT  idRs;
    regIdxT  idRt;
    regIdxT  idRd;
    aluOpT   idAluOp;
    logic    idAluSrcB;
    logic    idShamtSrc;
    dstSelT  idDstSel;
    readSelT idReadSel;
    branchT  idBranch;
    logic    idRegWr;
    wordT    memResult;
    regIdxT  memDst;
    logic    memRegWr;
    logic    memOverflow;
    wordT    memPc;
    logic    exeFlushId;
    wordT    branchTarget;
    logic    mdStall;

    int          cyc = 0;
    int          errVal = 0;
    int          errOther = 0;
    bit          aborted = 1'b0;
    logic [31:0] col [NumCols];    // fields of the current stimulus line
    int          expDue [MaxItems];    // cycle when the item sits in EXE
    wordT        expRes [MaxItems];
    regIdxT      expDst [MaxItems];
    logic        expWr [MaxItems];
    logic        expOv [MaxItems];
    logic        expFl [MaxItems];
    wordT        expTgt [MaxItems];
    wordT        expPc [MaxItems];
    string       expName [MaxItems];
    int          flushQ [$];
    int          memQ [$];

    exeTop i_exeTop (.*);

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic checkWord(input string name, input wordT expV, input wordT actV);
        if (actV !== expV) begin
            errVal++;
            $display("[FAIL] %s: expected %h, got %h", name, expV, actV);
        end
    endtask

    task automatic checkIdx(input string name, input regIdxT expV, input regIdxT actV);
        if (actV !== expV) begin
            errVal++;
            $display("[FAIL] %s: expected %0d, got %0d", name, expV, actV);
        end
    endtask

    task automatic checkBit(input string name, input logic expV, input logic actV);
        if (actV !== expV) begin
            errVal++;
            $display("[FAIL] %s: expected %b, got %b", name, expV, actV);
        end
    endtask

    // no-op that still moves the pipeline
    task automatic driveNop();
        @(posedge clk);
        exeWr      <= 1'b1;
        exeFlush   <= 1'b0;
        idRs       <= '0;
        idRt       <= '0;
        idAluOp    <= addU;
        idAluSrcB  <= 1'b0;
        idShamtSrc <= 1'b0;
        idDstSel   <= dstRd;
        idReadSel  <= selAlu;
        idBranch   <= brNone;
        idRegWr    <= 1'b0;
    endtask

    task automatic driveLine(input int id);
        @(posedge clk);
        exeWr      <= 1'b1;
        exeFlush   <= 1'b0;
        idBusA     <= col[2];
        idBusB     <= col[3];
        idImm      <= col[4];
        idPc       <= col[5];
        idRs       <= regIdxT'(col[6]);
        idRt       <= regIdxT'(col[7]);
        idRd       <= regIdxT'(col[8]);
        idAluOp    <= aluOpT'(col[9][4:0]);
        idAluSrcB  <= col[10][0];
        idShamtSrc <= col[11][0];
        idDstSel   <= dstSelT'(col[12][1:0]);
        idReadSel  <= readSelT'(col[13][1:0]);
        idBranch   <= branchT'(col[14][2:0]);
        idRegWr    <= col[15][0];
        expDue[id] = cyc + 2;    // sampled at the next edge
    endtask

    task automatic pushExpect(input int id);
        expRes[id] = col[16];
        expDst[id] = regIdxT'(col[17]);
        expWr[id]  = col[18][0];
        expOv[id]  = col[19][0];
        expFl[id]  = col[20][0];
        expTgt[id] = col[5] + 32'd4 + (col[4] << 2);
        expPc[id]  = col[5];
        flushQ.push_back(id);
        memQ.push_back(id);
    endtask

    task automatic waitStallLow(input string name, output int stallCycles);
        int t;
        t = 0;
        stallCycles = 0;
        @(negedge clk);
        while (mdStall && t < StallLimit) begin
            if (t > 0) begin
                checkBit({name, " bubble"}, 1'b0, memRegWr);    // older op already gone
            end
            stallCycles++;
            t++;
            @(negedge clk);
        end
        if (mdStall) begin
            $display("Timeout: mdStall of %s is still high after %0d cycles", name, t);
            errOther++;
            aborted = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        int fid;
        int mid;
        if (flushQ.size() > 0 && cyc == expDue[flushQ[0]]) begin
            fid = flushQ.pop_front();
            checkBit({expName[fid], " exeFlushId"}, expFl[fid], exeFlushId);
            if (expFl[fid]) begin
                checkWord({expName[fid], " branchTarget"}, expTgt[fid], branchTarget);
            end
        end
        if (memQ.size() > 0 && cyc == expDue[memQ[0]] + 1) begin
            mid = memQ.pop_front();
            checkBit({expName[mid], " memRegWr"}, expWr[mid], memRegWr);
            checkBit({expName[mid], " memOverflow"}, expOv[mid], memOverflow);
            checkWord({expName[mid], " memPc"}, expPc[mid], memPc);
            if (expWr[mid]) begin
                checkWord({expName[mid], " memResult"}, expRes[mid], memResult);
                checkIdx({expName[mid], " memDst"}, expDst[mid], memDst);
            end
        end
    end

    initial begin
        int    fd;
        int    n;
        int    id;
        int    gap;
        int    t;
        int    seedVal;
        int    stallCycles;
        int    assertFails;
        string line;
        string name;
        aluOpT op;

        rstN       = 1'b0;
        exeWr      = 1'b0;
        exeFlush   = 1'b0;
        idBusA     = '0;
        idBusB     = '0;
        idImm      = '0;
        idPc       = '0;
        idRs       = '0;
        idRt       = '0;
        idRd       = '0;
        idAluOp    = addU;
        idAluSrcB  = 1'b0;
        idShamtSrc = 1'b0;
        idDstSel   = dstRd;
        idReadSel  = selAlu;
        idBranch   = brNone;
        idRegWr    = 1'b0;
        seedVal    = $urandom(32'hd6f1);
        id         = 0;

        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        fd = $fopen("exe_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open exe_stim.txt for reading");
            errOther++;
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd) && id < MaxItems) begin
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                col[14], col[15], col[16], col[17], col[18], col[19], col[20]);
            if (n == NumCols) begin
                op = aluOpT'(col[9][4:0]);
                name = $sformatf("item %0d (%s)", id, op.name());
                expName[id] = name;
                if (col[1][0] == 1'b0) begin
                    gap = $urandom_range(2, 0);    // chained items go back to back
                    repeat (gap) driveNop();
                end
                driveLine(id);
                if (col[0] == 32'd0) begin
                    pushExpect(id);
                end else begin
                    @(posedge clk);
                    exeWr <= 1'b0;    // keep mul/div in EXE
                    if (col[0] == 32'd2) begin
                        repeat (4) @(posedge clk);
                        exeFlush <= 1'b1;
                        @(posedge clk);
                        exeFlush <= 1'b0;
                    end
                    waitStallLow(name, stallCycles);
                    if (col[0] == 32'd1 && !aborted && stallCycles != `EXE_MD_CYCLES) begin
                        $display("%s stalled for %0d cycles instead of %0d",
                            name, stallCycles, `EXE_MD_CYCLES);
                        errOther++;
                    end
                    if (col[0] == 32'd2 && !aborted && stallCycles != 0) begin
                        $display("%s kept mdStall high for %0d cycles after the flush",
                            name, stallCycles);
                        errOther++;
                    end
                end
                id++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        t = 0;
        while (memQ.size() > 0 && t < DrainLimit) begin
            driveNop();
            t++;
        end
        if (memQ.size() > 0) begin
            $display("Timeout: %0d results never reached the MEM outputs", memQ.size());
            errOther++;
        end
        @(negedge clk);

        assertFails = i_exeTop.i_exeChecker.failCnt;
        $display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
            errVal, errOther, assertFails);
        if (errVal == 0 && errOther == 0 && assertFails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- exe_checker.sv
`timescale 1ns/1ps
`include "exe_macros.svh"

module exeChecker (
    input logic clk,
    input logic rstN,
    input logic mdStall,
    input logic memRegWr,
    input logic memOverflow
);

    int stallLen;    // consecutive stall cycles so far
    int failCnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stallLen <= 0;
        end else if (mdStall) begin
            stallLen <= stallLen + 1;
        end else begin
            stallLen <= 0;
        end
    end

    initial failCnt = 0;

    writeOrTrap: assert property (@(posedge clk) disable iff (!rstN)
        !(memRegWr && memOverflow))
        else begin
            $error("memRegWr and memOverflow are high together");
            failCnt++;
        end

    stallBounded: assert property (@(posedge clk) disable iff (!rstN)
        stallLen < `EXE_MD_CYCLES + 2)
        else begin
            $error("mdStall stayed high too long");
            failCnt++;
        end

    bubbleAfterStall: assert property (@(posedge clk) disable iff (!rstN)
        mdStall |=> !memRegWr)
        else begin
            $error("register write left EXE/MEM right after a stall cycle");
            failCnt++;
        end

endmodule

bind exeTop exeChecker i_exeChecker (
    .clk         (clk),
    .rstN        (rstN),
    .mdStall     (mdStall),
    .memRegWr    (memRegWr),
    .memOverflow (memOverflow)
);

//--- exeTop.sv
`timescale 1ns/1ps

module exeTop (
    input  logic             clk,
    input  logic             rstN,
    input  logic             exeWr,
    input  logic             exeFlush,
    input  exePkg::wordT     idBusA,
    input  exePkg::wordT     idBusB,
    input  exePkg::wordT     idImm,
    input  exePkg::wordT     idPc,
    input  exePkg::regIdxT   idRs,
    input  exePkg::regIdxT   idRt,
    input  exePkg::regIdxT   idRd,
    input  exePkg::aluOpT    idAluOp,
    input  logic             idAluSrcB,
    input  logic             idShamtSrc,
    input  exePkg::dstSelT   idDstSel,
    input  exePkg::readSelT  idReadSel,
    input  exePkg::branchT   idBranch,
    input  logic             idRegWr,
    output exePkg::wordT     memResult,
    output exePkg::regIdxT   memDst,
    output logic             memRegWr,
    output logic             memOverflow,
    output exePkg::wordT     memPc,
    output logic             exeFlushId,
    output exePkg::wordT     branchTarget,
    output logic             mdStall
);
    import exePkg::*;

    wordT     exeBusA;
    wordT     exeBusB;
    wordT     exeImm;
    wordT     exePc;
    regIdxT   exeRs;
    regIdxT   exeRt;
    regIdxT   exeRd;
    aluOpT    exeAluOp;
    logic     exeAluSrcB;
    logic     exeShamtSrc;
    dstSelT   exeDstSel;
    readSelT  exeReadSel;
    branchT   exeBranch;
    logic     exeRegWr;
    wordT     stageResult;
    regIdxT   stageDst;
    logic     stageRegWr;
    logic     stageOverflow;

    idExeReg i_idExeReg (
        .clk         (clk),
        .rstN        (rstN),
        .exeWr       (exeWr),
        .exeFlush    (exeFlush),
        .idBusA      (idBusA),
        .idBusB      (idBusB),
        .idImm       (idImm),
        .idPc        (idPc),
        .idRs        (idRs),
        .idRt        (idRt),
        .idRd        (idRd),
        .idAluOp     (idAluOp),
        .idAluSrcB   (idAluSrcB),
        .idShamtSrc  (idShamtSrc),
        .idDstSel    (idDstSel),
        .idReadSel   (idReadSel),
        .idBranch    (idBranch),
        .idRegWr     (idRegWr),
        .exeBusA     (exeBusA),
        .exeBusB     (exeBusB),
        .exeImm      (exeImm),
        .exePc       (exePc),
        .exeRs       (exeRs),
        .exeRt       (exeRt),
        .exeRd       (exeRd),
        .exeAluOp    (exeAluOp),
        .exeAluSrcB  (exeAluSrcB),
        .exeShamtSrc (exeShamtSrc),
        .exeDstSel   (exeDstSel),
        .exeReadSel  (exeReadSel),
        .exeBranch   (exeBranch),
        .exeRegWr    (exeRegWr)
    );

    exeStage i_exeStage (
        .clk          (clk),
        .rstN         (rstN),
        .exeWr        (exeWr),
        .exeFlush     (exeFlush),
        .exeBusA      (exeBusA),
        .exeBusB      (exeBusB),
        .exeImm       (exeImm),
        .exePc        (exePc),
        .exeRs        (exeRs),
        .exeRt        (exeRt),
        .exeRd        (exeRd),
        .exeAluOp     (exeAluOp),
        .exeAluSrcB   (exeAluSrcB),
        .exeShamtSrc  (exeShamtSrc),
        .exeDstSel    (exeDstSel),
        .exeReadSel   (exeReadSel),
        .exeBranch    (exeBranch),
        .exeRegWr     (exeRegWr),
        .memResult    (memResult),    // MEM feedback for forwarding
        .memDst       (memDst),
        .memRegWr     (memRegWr),
        .result       (stageResult),
        .dst          (stageDst),
        .regWr        (stageRegWr),
        .overflow     (stageOverflow),
        .exeFlushId   (exeFlushId),
        .branchTarget (branchTarget),
        .mdStall      (mdStall)
    );

    exeMemReg i_exeMemReg (
        .clk         (clk),
        .rstN        (rstN),
        .mdStall     (mdStall),
        .result      (stageResult),
        .dst         (stageDst),
        .regWr       (stageRegWr),
        .overflow    (stageOverflow),
        .pc          (exePc),
        .memResult   (memResult),
        .memDst      (memDst),
        .memRegWr    (memRegWr),
        .memOverflow (memOverflow),
        .memPc       (memPc)
    );

endmodule

//--- exeMemReg.sv
`timescale 1ns/1ps

module exeMemReg (
    input  logic            clk,
    input  logic            rstN,
    input  logic            mdStall,
    input  exePkg::wordT    result,
    input  exePkg::regIdxT  dst,
    input  logic            regWr,
    input  logic            overflow,
    input  exePkg::wordT    pc,
    output exePkg::wordT    memResult,
    output exePkg::regIdxT  memDst,
    output logic            memRegWr,
    output logic            memOverflow,
    output exePkg::wordT    memPc
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memRegWr    <= 1'b0;
            memOverflow <= 1'b0;
        end else if (mdStall) begin
            memRegWr    <= 1'b0;    // bubble while mul/div iterates
            memOverflow <= 1'b0;
        end else begin
            memRegWr    <= regWr;
            memOverflow <= overflow;
        end
    end

    always_ff @(posedge clk) begin
        memResult <= result;
        memDst    <= dst;
        memPc     <= pc;
    end

endmodule

//--- exeStage.sv
`timescale 1ns/1ps
`include "exe_macros.svh"

module exeStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             exeWr,
    input  logic             exeFlush,
    input  exePkg::wordT     exeBusA,
    input  exePkg::wordT     exeBusB,
    input  exePkg::wordT     exeImm,
    input  exePkg::wordT     exePc,
    input  exePkg::regIdxT   exeRs,
    input  exePkg::regIdxT   exeRt,
    input  exePkg::regIdxT   exeRd,
    input  exePkg::aluOpT    exeAluOp,
    input  logic             exeAluSrcB,
    input  logic             exeShamtSrc,
    input  exePkg::dstSelT   exeDstSel,
    input  exePkg::readSelT  exeReadSel,
    input  exePkg::branchT   exeBranch,
    input  logic             exeRegWr,
    input  exePkg::wordT     memResult,
    input  exePkg::regIdxT   memDst,
    input  logic             memRegWr,
    output exePkg::wordT     result,
    output exePkg::regIdxT   dst,
    output logic             regWr,
    output logic             overflow,
    output logic             exeFlushId,
    output exePkg::wordT     branchTarget,
    output logic             mdStall
);
    import exePkg::*;

    logic fwdA;
    logic fwdB;
    logic aluOv;
    wordT busA;
    wordT busB;
    wordT opA;
    wordT opB;
    wordT aluOut;
    wordT hi;
    wordT lo;

    // r0 is never forwarded
    assign fwdA = memRegWr && (memDst != '0) && (memDst == exeRs);
    assign fwdB = memRegWr && (memDst != '0) && (memDst == exeRt);
    assign busA = fwdA ? memResult : exeBusA;
    assign busB = fwdB ? memResult : exeBusB;
    assign opA  = exeShamtSrc ? wordT'(exeImm[10:6]) : busA;
    assign opB  = exeAluSrcB ? exeImm : busB;

    exeAlu i_exeAlu (
        .opA      (opA),
        .opB      (opB),
        .aluOp    (exeAluOp),
        .aluOut   (aluOut),
        .overflow (aluOv)
    );

    mulDivUnit i_mulDivUnit (
        .clk     (clk),
        .rstN    (rstN),
        .abort   (exeFlush),
        .opA     (busA),
        .opB     (busB),
        .aluOp   (exeAluOp),
        .commit  (exeWr),     // mthi/mtlo land as the op leaves EXE
        .hi      (hi),
        .lo      (lo),
        .mdStall (mdStall)
    );

    always_comb begin
        unique case (exeBranch)
            brEq:     exeFlushId = (busA == busB);
            brNe:     exeFlushId = (busA != busB);
            brGez:    exeFlushId = !busA[`EXE_XLEN-1];
            brLtz:    exeFlushId = busA[`EXE_XLEN-1];
            brAlways: exeFlushId = 1'b1;
            default:  exeFlushId = 1'b0;
        endcase
    end

    assign branchTarget = exePc + wordT'(4) + (exeImm << 2);

    always_comb begin
        unique case (exeDstSel)
            dstRt:   dst = exeRt;
            dstRa:   dst = regIdxT'(`EXE_RA_IDX);
            default: dst = exeRd;
        endcase
    end

    always_comb begin
        if (exeDstSel == dstRa) begin
            result = exePc + wordT'(8);    // return address past delay slot
        end else begin
            unique case (exeReadSel)
                selHi:   result = hi;
                selLo:   result = lo;
                default: result = aluOut;
            endcase
        end
    end

    assign regWr    = exeRegWr && !aluOv;    // squash on overflow
    assign overflow = aluOv;

endmodule

//--- mulDivUnit.sv
`timescale 1ns/1ps
`include "exe_macros.svh"

module mulDivUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           abort,
    input  exePkg::wordT   opA,
    input  exePkg::wordT   opB,
    input  exePkg::aluOpT  aluOp,
    input  logic           commit,
    output exePkg::wordT   hi,
    output exePkg::wordT   lo,
    output logic           mdStall
);
    import exePkg::*;

    localparam int W    = `EXE_XLEN;
    localparam int CntW = $clog2(`EXE_MD_CYCLES);

    mdStateT         state;
    logic [CntW-1:0] cnt;
    logic            mdDone;    // result in HI/LO, op not yet left EXE
    logic            isMd;
    logic            isDivOp;
    logic            isSigned;
    logic            start;
    logic            lastIter;
    logic            busy;
    logic            stepDiv;
    logic            geq;
    logic            divReg;
    logic            negQ;
    logic            negR;
    logic            divZero;
    wordT            absA;
    wordT            absB;
    wordT            opReg;     // multiplicand or divisor magnitude
    wordT            stepOp;
    wordT            quoFix;
    wordT            remFix;
    dwordT           work;      // {acc, multiplier} or {rem, quotient}
    dwordT           stepIn;
    dwordT           stepOut;
    dwordT           prodFix;
    logic [W:0]      addSum;
    logic [W:0]      remShift;
    logic [W:0]      remDiff;

    assign isMd     = aluOp inside {mult, multu, div, divu};
    assign isDivOp  = aluOp inside {div, divu};
    assign isSigned = aluOp inside {mult, div};
    assign busy     = (state == mdBusy);
    assign start    = !busy && isMd && !mdDone && !abort;
    assign lastIter = busy && (cnt == CntW'(`EXE_MD_CYCLES - 1));
    assign mdStall  = busy || (isMd && !mdDone);

    assign absA = (isSigned && opA[W-1]) ? -opA : opA;
    assign absB = (isSigned && opB[W-1]) ? -opB : opB;

    // first iteration runs straight off the operands
    assign stepIn  = busy ? work : dwordT'(absA);
    assign stepOp  = busy ? opReg : absB;
    assign stepDiv = busy ? divReg : isDivOp;

    assign addSum   = {1'b0, stepIn[2*W-1:W]} + (stepIn[0] ? {1'b0, stepOp} : '0);
    assign remShift = {stepIn[2*W-1:W], stepIn[W-1]};
    assign geq      = remShift >= {1'b0, stepOp};
    assign remDiff  = remShift - {1'b0, stepOp};

    always_comb begin
        if (!stepDiv) begin
            stepOut = {addSum, stepIn[W-1:1]};
        end else if (geq) begin
            stepOut = {remDiff[W-1:0], stepIn[W-2:0], 1'b1};
        end else begin
            stepOut = {remShift[W-1:0], stepIn[W-2:0], 1'b0};
        end
    end

    assign prodFix = negQ ? -stepOut : stepOut;
    assign quoFix  = divZero ? '1 : (negQ ? -stepOut[W-1:0] : stepOut[W-1:0]);
    assign remFix  = negR ? -stepOut[2*W-1:W] : stepOut[2*W-1:W];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= mdIdle;
            cnt    <= '0;
            mdDone <= 1'b0;
        end else begin
            unique case (state)
                mdIdle: begin
                    if (start) begin
                        state <= mdBusy;
                        cnt   <= CntW'(1);
                    end
                end
                mdBusy: begin
                    if (abort || lastIter) begin
                        state <= mdIdle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
            if (abort || commit) begin
                mdDone <= 1'b0;
            end else if (lastIter) begin
                mdDone <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            work    <= stepOut;
            opReg   <= absB;
            divReg  <= isDivOp;
            negQ    <= isSigned && (opA[W-1] ^ opB[W-1]);
            negR    <= isSigned && opA[W-1];    // remainder follows dividend
            divZero <= isDivOp && (opB == '0);
        end else if (busy) begin
            work <= stepOut;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (lastIter && !abort) begin
            hi <= divReg ? remFix : prodFix[2*W-1:W];
            lo <= divReg ? quoFix : prodFix[W-1:0];
        end else if (commit && !abort) begin
            if (aluOp == mthi) hi <= opA;
            if (aluOp == mtlo) lo <= opA;
        end
    end

endmodule

//--- exeAlu.sv
`timescale 1ns/1ps
`include "exe_macros.svh"

module exeAlu (
    input  exePkg::wordT   opA,
    input  exePkg::wordT   opB,
    input  exePkg::aluOpT  aluOp,
    output exePkg::wordT   aluOut,
    output logic           overflow
);
    import exePkg::*;

    localparam int Msb = `EXE_XLEN - 1;
    localparam int ShW = $clog2(`EXE_XLEN);

    wordT           sum;
    wordT           diff;
    logic [ShW-1:0] shAmt;

    assign sum   = opA + opB;
    assign diff  = opA - opB;
    assign shAmt = opA[ShW-1:0];    // shamt or rs for the variable shifts

    always_comb begin
        unique case (aluOp)
            addS, addU: aluOut = sum;
            subS, subU: aluOut = diff;
            andOp:      aluOut = opA & opB;
            orOp:       aluOut = opA | opB;
            xorOp:      aluOut = opA ^ opB;
            norOp:      aluOut = ~(opA | opB);
            slt:        aluOut = wordT'($signed(opA) < $signed(opB));
            sltu:       aluOut = wordT'(opA < opB);
            sll:        aluOut = opB << shAmt;
            srl:        aluOut = opB >> shAmt;
            sra:        aluOut = $signed(opB) >>> shAmt;
            lui:        aluOut = opB << (`EXE_XLEN / 2);
            mult, multu, div, divu,
            mthi, mtlo: aluOut = opA;        // hi/lo path uses rs
            default:    aluOut = '0;
        endcase
    end

    // sign rule, carries ignored
    always_comb begin
        unique case (aluOp)
            addS:    overflow = (opA[Msb] == opB[Msb]) && (sum[Msb] != opA[Msb]);
            subS:    overflow = (opA[Msb] != opB[Msb]) && (diff[Msb] != opA[Msb]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

//--- idExeReg.sv
`timescale 1ns/1ps

module idExeReg (
    input  logic             clk,
    input  logic             rstN,
    input  logic             exeWr,
    input  logic             exeFlush,
    input  exePkg::wordT     idBusA,
    input  exePkg::wordT     idBusB,
    input  exePkg::wordT     idImm,
    input  exePkg::wordT     idPc,
    input  exePkg::regIdxT   idRs,
    input  exePkg::regIdxT   idRt,
    input  exePkg::regIdxT   idRd,
    input  exePkg::aluOpT    idAluOp,
    input  logic             idAluSrcB,
    input  logic             idShamtSrc,
    input  exePkg::dstSelT   idDstSel,
    input  exePkg::readSelT  idReadSel,
    input  exePkg::branchT   idBranch,
    input  logic             idRegWr,
    output exePkg::wordT     exeBusA,
    output exePkg::wordT     exeBusB,
    output exePkg::wordT     exeImm,
    output exePkg::wordT     exePc,
    output exePkg::regIdxT   exeRs,
    output exePkg::regIdxT   exeRt,
    output exePkg::regIdxT   exeRd,
    output exePkg::aluOpT    exeAluOp,
    output logic             exeAluSrcB,
    output logic             exeShamtSrc,
    output exePkg::dstSelT   exeDstSel,
    output exePkg::readSelT  exeReadSel,
    output exePkg::branchT   exeBranch,
    output logic             exeRegWr
);
    import exePkg::*;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exeAluOp  <= addU;    // bubble
            exeBranch <= brNone;
            exeRegWr  <= 1'b0;
        end else if (exeFlush) begin
            exeAluOp  <= addU;
            exeBranch <= brNone;
            exeRegWr  <= 1'b0;
        end else if (exeWr) begin
            exeAluOp  <= idAluOp;
            exeBranch <= idBranch;
            exeRegWr  <= idRegWr;
        end
    end

    // operands and selects, harmless under a bubble
    always_ff @(posedge clk) begin
        if (exeWr) begin
            exeBusA     <= idBusA;
            exeBusB     <= idBusB;
            exeImm      <= idImm;
            exePc       <= idPc;
            exeRs       <= idRs;
            exeRt       <= idRt;
            exeRd       <= idRd;
            exeAluSrcB  <= idAluSrcB;
            exeShamtSrc <= idShamtSrc;
            exeDstSel   <= idDstSel;
            exeReadSel  <= idReadSel;
        end
    end

endmodule

//--- exePkg.sv
`include "exe_macros.svh"

package exePkg;

    typedef logic [`EXE_XLEN-1:0]     wordT;
    typedef logic [`EXE_REG_BITS-1:0] regIdxT;
    typedef logic [2*`EXE_XLEN-1:0]   dwordT;   // full product

    typedef enum logic [4:0] {
        addS, addU, subS, subU,
        andOp, orOp, xorOp, norOp,
        slt, sltu,
        sll, srl, sra,
        lui,
        mult, multu, div, divu,
        mthi, mtlo
    } aluOpT;

    typedef enum logic [2:0] {
        brNone, brEq, brNe, brGez, brLtz, brAlways
    } branchT;

    typedef enum logic [1:0] {
        dstRd, dstRt, dstRa
    } dstSelT;

    // mfhi/mflo pick HI or LO instead of the ALU
    typedef enum logic [1:0] {
        selAlu, selHi, selLo
    } readSelT;

    typedef enum logic {
        mdIdle, mdBusy
    } mdStateT;

endpackage

//--- exe_macros.svh
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// datapath width
`define EXE_XLEN 32

// register file index width
`define EXE_REG_BITS 5

// one iteration per result bit
`define EXE_MD_CYCLES 32

// link register for jal/bal style writes
`define EXE_RA_IDX 31

`endif
